// ==== hw/axi_bridge_macros.svh ====
`ifndef AXI_BRIDGE_MACROS_SVH
`define AXI_BRIDGE_MACROS_SVH

// bus widths
`define AXI_ADDR_W 32
`define AXI_DATA_W 32
`define AXI_ID_W 4
`define AXI_LEN_W 4 // axi3 style len field
`define AXI_STRB_W (`AXI_DATA_W / 8)

// cache line geometry, 64 byte lines
`define LINE_WORDS 16
`define LINE_W 512
`define LINE_OFS_W 6

// burst length fields
`define AXI_LEN_LINE `AXI_LEN_W'(`LINE_WORDS - 1)
`define AXI_LEN_SINGLE `AXI_LEN_W'(0)

// burst and response encodings
`define AXI_BURST_FIXED 2'b00
`define AXI_BURST_INCR 2'b01
`define AXI_RESP_OKAY 2'b00

// ids, read ids select the return port
`define RD_ID_ICACHE `AXI_ID_W'(0)
`define RD_ID_DCACHE `AXI_ID_W'(1)
`define WR_ID `AXI_ID_W'(1)

`endif

// ==== hw/axi_bridge_pkg.sv ====
`include "axi_bridge_macros.svh"

package axi_bridge_pkg;

	// sram-like read request from either cache
	typedef struct packed {
		logic [`AXI_ADDR_W-1:0] addr;
		logic [2:0] size;
		logic uncached; // single beat, fixed burst
	} cache_rd_req_t;

	// one beat back to a cache
	typedef struct packed {
		logic valid;
		logic last;
		logic [`AXI_DATA_W-1:0] data;
	} cache_ret_t;

	// dcache write, either a whole line or one word
	typedef struct packed {
		logic [`AXI_ADDR_W-1:0] addr;
		logic [2:0] size;
		logic [`AXI_STRB_W-1:0] strb; // uncached word only
		logic uncached;
		logic [`LINE_W-1:0] line; // word 0 in the low bits
		logic [`AXI_DATA_W-1:0] word;
	} cache_wr_req_t;

	typedef struct packed {
		logic [`AXI_ID_W-1:0] id;
		logic [`AXI_ADDR_W-1:0] addr;
		logic [`AXI_LEN_W-1:0] len;
		logic [2:0] size;
		logic [1:0] burst;
	} axi_ar_t;

	typedef struct packed {
		logic [`AXI_ID_W-1:0] id;
		logic [`AXI_DATA_W-1:0] data;
		logic [1:0] resp;
		logic last;
	} axi_r_t;

	typedef struct packed {
		logic [`AXI_ADDR_W-1:0] addr;
		logic [`AXI_LEN_W-1:0] len;
		logic [2:0] size;
		logic [1:0] burst;
	} axi_aw_t;

	typedef struct packed {
		logic [`AXI_DATA_W-1:0] data;
		logic [`AXI_STRB_W-1:0] strb;
		logic last;
	} axi_w_t;

	typedef struct packed {
		logic [1:0] resp;
	} axi_b_t;

endpackage

// ==== hw/axi_rd_path.sv ====
`include "axi_bridge_macros.svh"

module axi_rd_path (
	input  logic clk,
	input  logic rst,
	input  logic ic_rd_req,
	input  axi_bridge_pkg::cache_rd_req_t ic_rd,
	output logic ic_rd_rdy,
	output axi_bridge_pkg::cache_ret_t ic_ret,
	input  logic dc_rd_req,
	input  axi_bridge_pkg::cache_rd_req_t dc_rd,
	output logic dc_rd_rdy,
	output axi_bridge_pkg::cache_ret_t dc_ret,
	input  logic wr_busy,
	input  logic [`AXI_ADDR_W-`LINE_OFS_W-1:0] wr_line,
	output logic arvalid,
	input  logic arready,
	output axi_bridge_pkg::axi_ar_t ar,
	input  logic rvalid,
	input  axi_bridge_pkg::axi_r_t r
);
	typedef enum logic [1:0] {st_idle, st_addr, st_data} state_t;

	state_t state;
	state_t state_nxt;
	logic ic_hazard;
	logic dc_hazard;
	logic ic_take;
	logic dc_take;
	logic beat; // r beat while a burst is open
	axi_bridge_pkg::axi_ar_t ar_q;

	// ar payload for a request, id picks the return port later
	function automatic axi_bridge_pkg::axi_ar_t make_ar(
		input axi_bridge_pkg::cache_rd_req_t req,
		input logic [`AXI_ID_W-1:0] id
	);
		axi_bridge_pkg::axi_ar_t a;
		a.id = id;
		a.addr = req.addr;
		a.len = req.uncached ? `AXI_LEN_SINGLE : `AXI_LEN_LINE;
		a.size = req.size;
		a.burst = req.uncached ? `AXI_BURST_FIXED : `AXI_BURST_INCR;
		return a;
	endfunction

	// hold off reads to a line that is still being written
	assign ic_hazard = wr_busy && (ic_rd.addr[`AXI_ADDR_W-1:`LINE_OFS_W] == wr_line);
	assign dc_hazard = wr_busy && (dc_rd.addr[`AXI_ADDR_W-1:`LINE_OFS_W] == wr_line);

	assign ic_rd_rdy = (state == st_idle) && !ic_hazard;
	assign ic_take = ic_rd_req && ic_rd_rdy;
	assign dc_rd_rdy = (state == st_idle) && !dc_hazard && !ic_take; // icache first
	assign dc_take = dc_rd_req && dc_rd_rdy;

	always_ff @(posedge clk) begin
		if (!rst) begin
			state <= st_idle;
		end else begin
			state <= state_nxt;
		end
	end

	always_comb begin
		state_nxt = state;
		case (state)
			st_idle: begin
				if (ic_take || dc_take) begin
					state_nxt = st_addr;
				end
			end
			st_addr: begin
				if (arready) begin
					state_nxt = st_data;
				end
			end
			st_data: begin
				if (beat && r.last) begin
					state_nxt = st_idle;
				end
			end
			default: state_nxt = st_idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (ic_take) begin
			ar_q <= make_ar(ic_rd, `RD_ID_ICACHE);
		end else if (dc_take) begin
			ar_q <= make_ar(dc_rd, `RD_ID_DCACHE);
		end
	end

	assign arvalid = (state == st_addr);
	assign ar = ar_q;

	assign beat = (state == st_data) && rvalid; // rready is always high

	// route beats back by id
	always_comb begin
		ic_ret.valid = beat && (r.id == `RD_ID_ICACHE);
		ic_ret.last = ic_ret.valid && r.last;
		ic_ret.data = r.data;
		dc_ret.valid = beat && (r.id == `RD_ID_DCACHE);
		dc_ret.last = dc_ret.valid && r.last;
		dc_ret.data = r.data;
	end

	a_ar_stable: assert property (@(posedge clk) disable iff (!rst)
		arvalid && !arready |=> arvalid && $stable(ar));

	// each beat reaches exactly one cache, a foreign id would be lost
	a_ret_onehot: assert property (@(posedge clk) disable iff (!rst)
		beat |-> (ic_ret.valid != dc_ret.valid));

endmodule

// ==== hw/axi_wr_path.sv ====
`include "axi_bridge_macros.svh"

module axi_wr_path (
	input  logic clk,
	input  logic rst,
	input  logic dc_wr_req,
	input  axi_bridge_pkg::cache_wr_req_t dc_wr,
	output logic dc_wr_rdy,
	output logic awvalid,
	input  logic awready,
	output axi_bridge_pkg::axi_aw_t aw,
	output logic wvalid,
	input  logic wready,
	output axi_bridge_pkg::axi_w_t w,
	input  logic bvalid,
	input  axi_bridge_pkg::axi_b_t b,
	output logic wr_busy,
	output logic [`AXI_ADDR_W-`LINE_OFS_W-1:0] wr_line
);
	typedef enum logic [1:0] {st_idle, st_addr, st_data, st_resp} state_t;

	state_t state;
	state_t state_nxt;
	logic accept;
	logic beat; // w handshake
	logic unc_q;
	logic [`AXI_LEN_W-1:0] beat_cnt;
	logic [`LINE_W-1:0] line_buf;
	logic [`AXI_DATA_W-1:0] word_q;
	logic [`AXI_STRB_W-1:0] strb_q;
	logic [`AXI_ADDR_W-`LINE_OFS_W-1:0] line_q;
	axi_bridge_pkg::axi_aw_t aw_q;

	assign dc_wr_rdy = (state == st_idle);
	assign accept = dc_wr_req && dc_wr_rdy;
	assign beat = wvalid && wready;

	always_ff @(posedge clk) begin
		if (!rst) begin
			state <= st_idle;
		end else begin
			state <= state_nxt;
		end
	end

	always_comb begin
		state_nxt = state;
		case (state)
			st_idle: begin
				if (accept) begin
					state_nxt = st_addr;
				end
			end
			st_addr: begin
				if (awready) begin
					state_nxt = st_data;
				end
			end
			st_data: begin
				if (beat && w.last) begin
					state_nxt = st_resp;
				end
			end
			st_resp: begin
				if (bvalid) begin // bready is always high
					state_nxt = st_idle;
				end
			end
			default: state_nxt = st_idle;
		endcase
	end

	// latch the whole request, the cache may drop it after the handshake
	always_ff @(posedge clk) begin
		if (accept) begin
			aw_q.addr <= dc_wr.addr;
			aw_q.len <= dc_wr.uncached ? `AXI_LEN_SINGLE : `AXI_LEN_LINE;
			aw_q.size <= dc_wr.size;
			aw_q.burst <= dc_wr.uncached ? `AXI_BURST_FIXED : `AXI_BURST_INCR;
			unc_q <= dc_wr.uncached;
			word_q <= dc_wr.word;
			strb_q <= dc_wr.strb;
			line_q <= dc_wr.addr[`AXI_ADDR_W-1:`LINE_OFS_W];
			line_buf <= dc_wr.line;
		end else if (beat) begin
			// next word moves down into the low bits
			line_buf <= {{`AXI_DATA_W{1'b0}}, line_buf[`LINE_W-1:`AXI_DATA_W]};
		end
	end

	always_ff @(posedge clk) begin
		if (!rst) begin
			beat_cnt <= '0;
		end else if (accept) begin
			beat_cnt <= '0;
		end else if (beat) begin
			beat_cnt <= beat_cnt + 1'b1;
		end
	end

	assign awvalid = (state == st_addr);
	assign aw = aw_q;
	assign wvalid = (state == st_data);

	always_comb begin
		w.data = unc_q ? word_q : line_buf[`AXI_DATA_W-1:0];
		w.strb = unc_q ? strb_q : {`AXI_STRB_W{1'b1}}; // full words for a line
		w.last = unc_q || (beat_cnt == `AXI_LEN_LINE);
	end

	// acceptance cycle included so a read in the same cycle is held too
	assign wr_busy = (state != st_idle) || accept;
	assign wr_line = accept ? dc_wr.addr[`AXI_ADDR_W-1:`LINE_OFS_W] : line_q;

	// data phase opens only after the aw handshake
	a_w_after_aw: assert property (@(posedge clk) disable iff (!rst)
		$rose(wvalid) |-> $past(state == st_addr && awready));

	a_b_okay: assert property (@(posedge clk) disable iff (!rst)
		(state == st_resp) && bvalid |-> b.resp == `AXI_RESP_OKAY);

endmodule

// ==== hw/axi_cache_bridge.sv ====
`include "axi_bridge_macros.svh"

module axi_cache_bridge (
	input  logic clk,
	input  logic rst,
	// icache read port
	input  logic ic_rd_req,
	input  axi_bridge_pkg::cache_rd_req_t ic_rd,
	output logic ic_rd_rdy,
	output axi_bridge_pkg::cache_ret_t ic_ret,
	// dcache read port
	input  logic dc_rd_req,
	input  axi_bridge_pkg::cache_rd_req_t dc_rd,
	output logic dc_rd_rdy,
	output axi_bridge_pkg::cache_ret_t dc_ret,
	// dcache write port
	input  logic dc_wr_req,
	input  axi_bridge_pkg::cache_wr_req_t dc_wr,
	output logic dc_wr_rdy,
	// axi master side, rready and bready tied high
	output logic arvalid,
	input  logic arready,
	output axi_bridge_pkg::axi_ar_t ar,
	input  logic rvalid,
	input  axi_bridge_pkg::axi_r_t r,
	output logic awvalid,
	input  logic awready,
	output axi_bridge_pkg::axi_aw_t aw,
	output logic wvalid,
	input  logic wready,
	output axi_bridge_pkg::axi_w_t w,
	input  logic bvalid,
	input  axi_bridge_pkg::axi_b_t b
);
	logic wr_busy;
	logic [`AXI_ADDR_W-`LINE_OFS_W-1:0] wr_line; // line being written

	axi_rd_path u_rd (
		.clk(clk),
		.rst(rst),
		.ic_rd_req(ic_rd_req),
		.ic_rd(ic_rd),
		.ic_rd_rdy(ic_rd_rdy),
		.ic_ret(ic_ret),
		.dc_rd_req(dc_rd_req),
		.dc_rd(dc_rd),
		.dc_rd_rdy(dc_rd_rdy),
		.dc_ret(dc_ret),
		.wr_busy(wr_busy),
		.wr_line(wr_line),
		.arvalid(arvalid),
		.arready(arready),
		.ar(ar),
		.rvalid(rvalid),
		.r(r)
	);

	axi_wr_path u_wr (
		.clk(clk),
		.rst(rst),
		.dc_wr_req(dc_wr_req),
		.dc_wr(dc_wr),
		.dc_wr_rdy(dc_wr_rdy),
		.awvalid(awvalid),
		.awready(awready),
		.aw(aw),
		.wvalid(wvalid),
		.wready(wready),
		.w(w),
		.bvalid(bvalid),
		.b(b),
		.wr_busy(wr_busy),
		.wr_line(wr_line)
	);

endmodule

// ==== sim/axi_slave_model.sv ====
`include "axi_bridge_macros.svh"

module axi_slave_model #(
	parameter logic [31:0] seed = 32'hae82
) (
	input  logic clk,
	input  logic rst,
	input  logic arvalid,
	output logic arready,
	input  axi_bridge_pkg::axi_ar_t ar,
	output logic rvalid,
	output axi_bridge_pkg::axi_r_t r,
	input  logic awvalid,
	output logic awready,
	input  axi_bridge_pkg::axi_aw_t aw,
	input  logic wvalid,
	output logic wready,
	input  axi_bridge_pkg::axi_w_t w,
	output logic bvalid,
	output axi_bridge_pkg::axi_b_t b
);
	timeunit 1ns;
	timeprecision 1ps;

	logic [`AXI_DATA_W-1:0] mem [0:1023];
	logic [31:0] lfsr;
	logic ar_go;
	logic aw_go;
	logic w_go;
	logic rd_busy; // one burst at a time
	logic [`AXI_LEN_W-1:0] rd_cnt;
	axi_bridge_pkg::axi_ar_t rd_q;
	logic [1:0] wr_st; // 0 idle, 1 data, 2 resp
	logic [`AXI_ADDR_W-1:0] wr_addr;
	logic [1:0] wr_burst;

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	// one lfsr step per ready bit
	always @(posedge clk) begin : stall_coins
		logic [31:0] s;
		s = lfsr;
		if (!rst) begin
			lfsr <= seed;
			ar_go <= 1'b0;
			aw_go <= 1'b0;
			w_go <= 1'b0;
		end else begin
			ar_go <= s[0];
			s = lfsr_step(s);
			aw_go <= s[0];
			s = lfsr_step(s);
			w_go <= s[0];
			lfsr <= lfsr_step(s);
		end
	end

	assign arready = ar_go && !rd_busy;
	assign rvalid = rd_busy; // rready is always high

	always_comb begin
		r.id = rd_q.id;
		r.data = mem[rd_q.addr[11:2]];
		r.resp = `AXI_RESP_OKAY;
		r.last = (rd_cnt == rd_q.len);
	end

	always @(posedge clk) begin
		if (!rst) begin
			rd_busy <= 1'b0;
		end else if (!rd_busy) begin
			if (arvalid && arready) begin
				rd_busy <= 1'b1;
				rd_q <= ar;
				rd_cnt <= '0;
			end
		end else if (rd_cnt == rd_q.len) begin
			rd_busy <= 1'b0;
		end else begin
			rd_cnt <= rd_cnt + 1'b1;
			if (rd_q.burst == `AXI_BURST_INCR) begin
				rd_q.addr <= rd_q.addr + 32'd4;
			end
		end
	end

	assign awready = aw_go && (wr_st == 2'd0);
	assign wready = w_go && (wr_st == 2'd1);
	assign bvalid = (wr_st == 2'd2); // held for one cycle
	assign b.resp = `AXI_RESP_OKAY;

	always @(posedge clk) begin
		if (!rst) begin
			wr_st <= 2'd0;
			for (int i = 0; i < 1024; i++) begin
				mem[i] <= (32'(i) << 2) ^ 32'h5a5a0000; // byte address xor tag
			end
		end else begin
			case (wr_st)
				2'd0: begin
					if (awvalid && awready) begin
						wr_addr <= aw.addr;
						wr_burst <= aw.burst;
						wr_st <= 2'd1;
					end
				end
				2'd1: begin
					if (wvalid && wready) begin
						for (int k = 0; k < `AXI_STRB_W; k++) begin
							if (w.strb[k]) begin
								mem[wr_addr[11:2]][8*k +: 8] <= w.data[8*k +: 8];
							end
						end
						if (wr_burst == `AXI_BURST_INCR) begin
							wr_addr <= wr_addr + 32'd4;
						end
						if (w.last) begin
							wr_st <= 2'd2;
						end
					end
				end
				default: wr_st <= 2'd0;
			endcase
		end
	end

endmodule

// ==== sim/tb_axi_cache_bridge.sv ====
`include "axi_bridge_macros.svh"

module tb_axi_cache_bridge;
	timeunit 1ns;
	timeprecision 1ps;

	typedef enum logic [1:0] {k_rd, k_wr, k_rd2, k_wrrd} kind_t;

	typedef struct packed {
		kind_t kind;
		logic dc; // data cache port, else instruction cache
		logic [`AXI_ADDR_W-1:0] addr;
		logic unc;
		logic [`AXI_DATA_W-1:0] wdata;
		logic [`AXI_DATA_W-1:0] exp; // first word, each later word adds 4
	} row_t;

	logic clk;
	logic rst;
	logic ic_rd_req;
	axi_bridge_pkg::cache_rd_req_t ic_rd;
	logic ic_rd_rdy;
	axi_bridge_pkg::cache_ret_t ic_ret;
	logic dc_rd_req;
	axi_bridge_pkg::cache_rd_req_t dc_rd;
	logic dc_rd_rdy;
	axi_bridge_pkg::cache_ret_t dc_ret;
	logic dc_wr_req;
	axi_bridge_pkg::cache_wr_req_t dc_wr;
	logic dc_wr_rdy;
	logic arvalid;
	logic arready;
	axi_bridge_pkg::axi_ar_t ar;
	logic rvalid;
	axi_bridge_pkg::axi_r_t r;
	logic awvalid;
	logic awready;
	axi_bridge_pkg::axi_aw_t aw;
	logic wvalid;
	logic wready;
	axi_bridge_pkg::axi_w_t w;
	logic bvalid;
	axi_bridge_pkg::axi_b_t b;

	row_t rows[$];
	string names[$];
	axi_bridge_pkg::cache_ret_t ic_q[$];
	axi_bridge_pkg::cache_ret_t dc_q[$];
	axi_bridge_pkg::axi_ar_t ar_seen[$]; // ar handshakes in order
	axi_bridge_pkg::axi_aw_t aw_seen[$];
	logic order_q[$]; // 1 for a dcache beat, in arrival order
	int cycles = 0;
	int cycle_limit = 0;

	axi_cache_bridge UUT (.*);

	axi_slave_model #(.seed(32'hae82)) u_slave (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycle_limit > 0 && cycles >= cycle_limit) begin
			$display("timeout: bridge stopped responding");
			$display("TEST FAILED");
			$fatal(1, "cycle limit reached");
		end
	end

	// collect return beats and address handshakes mid cycle
	always @(negedge clk) begin
		if (ic_ret.valid) begin
			ic_q.push_back(ic_ret);
			order_q.push_back(1'b0);
		end
		if (dc_ret.valid) begin
			dc_q.push_back(dc_ret);
			order_q.push_back(1'b1);
		end
		if (arvalid && arready) begin
			ar_seen.push_back(ar);
		end
		if (awvalid && awready) begin
			aw_seen.push_back(aw);
		end
	end

	task automatic fail_run(input string line);
		$display("%s", line);
		$display("TEST FAILED");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_ret(input string name, input axi_bridge_pkg::cache_ret_t want,
			input axi_bridge_pkg::cache_ret_t got);
		if (got.last !== want.last || got.data !== want.data) begin
			fail_run($sformatf("ERR %s: expected last=%0b data=%h, actual last=%0b data=%h",
				name, want.last, want.data, got.last, got.data));
		end
	endtask

	task automatic check_word(input string name, input logic [`AXI_DATA_W-1:0] want,
			input logic [`AXI_DATA_W-1:0] got);
		if (got !== want) begin
			fail_run($sformatf("ERR %s: expected %h, actual %h", name, want, got));
		end
	endtask

	task automatic check_ar(input string name, input axi_bridge_pkg::axi_ar_t want,
			input axi_bridge_pkg::axi_ar_t got);
		if (got !== want) begin
			fail_run($sformatf("ERR %s: expected %h, actual %h", name, want, got));
		end
	endtask

	task automatic check_aw(input string name, input axi_bridge_pkg::axi_aw_t want,
			input axi_bridge_pkg::axi_aw_t got);
		if (got !== want) begin
			fail_run($sformatf("ERR %s: expected %h, actual %h", name, want, got));
		end
	endtask

	task automatic check_count(input string name, input int want, input int got);
		if (got != want) begin
			fail_run($sformatf("ERR %s: expected %0d, actual %0d", name, want, got));
		end
	endtask

	// ar a read of n words should carry, one word means a fixed burst
	function automatic axi_bridge_pkg::axi_ar_t expect_ar(input logic dc,
			input logic [`AXI_ADDR_W-1:0] addr, input int n);
		axi_bridge_pkg::axi_ar_t a;
		a.id = dc ? `RD_ID_DCACHE : `RD_ID_ICACHE;
		a.addr = addr;
		a.len = `AXI_LEN_W'(n - 1);
		a.size = 3'd2;
		a.burst = (n == 1) ? `AXI_BURST_FIXED : `AXI_BURST_INCR;
		return a;
	endfunction

	function automatic axi_bridge_pkg::axi_aw_t expect_aw(input logic [`AXI_ADDR_W-1:0] addr,
			input int n);
		axi_bridge_pkg::axi_aw_t a;
		a.addr = addr;
		a.len = `AXI_LEN_W'(n - 1);
		a.size = 3'd2;
		a.burst = (n == 1) ? `AXI_BURST_FIXED : `AXI_BURST_INCR;
		return a;
	endfunction

	// entered and left 2 ns after a rising edge
	task automatic wait_taken(input int which);
		logic taken;
		taken = 1'b0;
		while (!taken) begin
			@(negedge clk);
			case (which)
				0: taken = ic_rd_rdy;
				1: taken = dc_rd_rdy;
				default: taken = dc_wr_rdy;
			endcase
			@(posedge clk);
			#2;
		end
	endtask

	task automatic send_read(input logic dc, input logic [`AXI_ADDR_W-1:0] addr, input logic unc);
		axi_bridge_pkg::cache_rd_req_t req;
		req.addr = addr;
		req.size = 3'd2;
		req.uncached = unc;
		if (dc) begin
			dc_rd = req;
			dc_rd_req = 1'b1;
			wait_taken(1);
			dc_rd_req = 1'b0;
		end else begin
			ic_rd = req;
			ic_rd_req = 1'b1;
			wait_taken(0);
			ic_rd_req = 1'b0;
		end
	endtask

	// icache at addr and dcache at the next line, raised together
	task automatic send_both(input logic [`AXI_ADDR_W-1:0] addr, input logic unc);
		logic ic_now;
		logic dc_now;
		ic_rd = '{addr: addr, size: 3'd2, uncached: unc};
		dc_rd = '{addr: addr + 32'h40, size: 3'd2, uncached: unc};
		ic_rd_req = 1'b1;
		dc_rd_req = 1'b1;
		while (ic_rd_req || dc_rd_req) begin
			@(negedge clk);
			ic_now = ic_rd_req && ic_rd_rdy;
			dc_now = dc_rd_req && dc_rd_rdy;
			@(posedge clk);
			#2;
			if (ic_now) ic_rd_req = 1'b0;
			if (dc_now) dc_rd_req = 1'b0;
		end
	endtask

	task automatic send_write(input logic [`AXI_ADDR_W-1:0] addr, input logic unc,
			input logic [`AXI_DATA_W-1:0] base);
		axi_bridge_pkg::cache_wr_req_t req;
		req = '0;
		req.addr = addr;
		req.size = 3'd2;
		req.strb = '1;
		req.uncached = unc;
		req.word = base;
		for (int k = 0; k < `LINE_WORDS; k++) begin
			req.line[`AXI_DATA_W*k +: `AXI_DATA_W] = base + 32'(4 * k);
		end
		dc_wr = req;
		dc_wr_req = 1'b1;
		wait_taken(2);
		dc_wr_req = 1'b0;
	endtask

	task automatic check_beats(input string name, input logic dc,
			input logic [`AXI_DATA_W-1:0] first, input int n);
		axi_bridge_pkg::cache_ret_t want;
		for (int k = 0; k < n; k++) begin
			want.valid = 1'b1;
			want.last = (k == n - 1);
			want.data = first + 32'(4 * k);
			check_ret($sformatf("%s beat %0d", name, k), want, dc ? dc_q[k] : ic_q[k]);
		end
	endtask

	task automatic run_row(input int i);
		row_t t;
		int n;
		int ic_n;
		int dc_n;
		int ar_n;
		int aw_n;
		int first_dc;
		logic [`AXI_DATA_W-1:0] dc_first;
		t = rows[i];
		n = t.unc ? 1 : `LINE_WORDS;
		ic_n = (t.kind == k_rd2 || (t.kind == k_rd && !t.dc)) ? n : 0;
		dc_n = (t.kind == k_rd2 || t.kind == k_wrrd || (t.kind == k_rd && t.dc)) ? n : 0;
		ar_n = (t.kind == k_rd2) ? 2 : ((t.kind == k_wr) ? 0 : 1);
		aw_n = (t.kind == k_wr || t.kind == k_wrrd) ? 1 : 0;
		ic_q.delete();
		dc_q.delete();
		order_q.delete();
		ar_seen.delete();
		aw_seen.delete();
		case (t.kind)
			k_rd: send_read(t.dc, t.addr, t.unc);
			k_rd2: send_both(t.addr, t.unc);
			k_wrrd: begin
				send_write(t.addr, t.unc, t.wdata);
				send_read(1'b1, t.addr, t.unc); // lands while the write is in flight
			end
			default: begin
				send_write(t.addr, t.unc, t.wdata);
				do @(negedge clk); while (!dc_wr_rdy);
				@(posedge clk);
				#2;
				for (int k = 0; k < n; k++) begin
					check_word($sformatf("%s word %0d", names[i], k), t.exp + 32'(4 * k),
						u_slave.mem[t.addr[11:2] + k]);
				end
			end
		endcase
		if (ic_n + dc_n > 0) begin
			do @(posedge clk); while (ic_q.size() < ic_n || dc_q.size() < dc_n);
			#2;
		end
		if (ic_n > 0) check_beats(names[i], 1'b0, t.exp, ic_n);
		if (dc_n > 0) begin
			dc_first = (t.kind == k_rd2) ? t.exp + 32'h40 : t.exp; // next line for k_rd2
			check_beats(names[i], 1'b1, dc_first, dc_n);
		end
		if (t.kind == k_rd2) begin
			first_dc = 0;
			while (first_dc < order_q.size() && !order_q[first_dc]) first_dc++;
			check_count({names[i], " icache beats before dcache"}, n, first_dc);
		end
		repeat (3) @(posedge clk); // room for a stray beat
		#2;
		check_count({names[i], " icache beats"}, ic_n, ic_q.size());
		check_count({names[i], " dcache beats"}, dc_n, dc_q.size());
		check_count({names[i], " ar count"}, ar_n, ar_seen.size());
		check_count({names[i], " aw count"}, aw_n, aw_seen.size());
		if (aw_n > 0) begin
			check_aw({names[i], " aw"}, expect_aw(t.addr, n), aw_seen[0]);
		end
		if (t.kind == k_rd2) begin
			check_ar({names[i], " icache ar"}, expect_ar(1'b0, t.addr, n), ar_seen[0]);
			check_ar({names[i], " dcache ar"}, expect_ar(1'b1, t.addr + 32'h40, n), ar_seen[1]);
		end else if (ar_n > 0) begin
			check_ar({names[i], " ar"}, expect_ar(t.dc, t.addr, n), ar_seen[0]);
		end
	endtask

	task automatic add_row(input string name, input kind_t kind, input logic dc,
			input logic [31:0] addr, input logic unc, input logic [31:0] wdata,
			input logic [31:0] exp);
		names.push_back(name);
		rows.push_back('{kind: kind, dc: dc, addr: addr, unc: unc, wdata: wdata, exp: exp});
	endtask

	initial begin
		rst = 1'b0;
		ic_rd_req = 1'b0;
		ic_rd = '0;
		dc_rd_req = 1'b0;
		dc_rd = '0;
		dc_wr_req = 1'b0;
		dc_wr = '0;
		// name, kind, dcache port, address, uncached, write data, expected first word
		add_row("ic_line", k_rd, 1'b0, 32'h040, 1'b0, 32'h0, 32'h5a5a0040);
		add_row("dc_unc_rd", k_rd, 1'b1, 32'h1a8, 1'b1, 32'h0, 32'h5a5a01a8);
		add_row("ic_unc_rd", k_rd, 1'b0, 32'h2f4, 1'b1, 32'h0, 32'h5a5a02f4);
		add_row("ic_dc_same", k_rd2, 1'b0, 32'h300, 1'b0, 32'h0, 32'h5a5a0300);
		add_row("line_wr", k_wr, 1'b1, 32'h200, 1'b0, 32'hc0de0000, 32'hc0de0000);
		add_row("line_rd_back", k_rd, 1'b1, 32'h200, 1'b0, 32'h0, 32'hc0de0000);
		add_row("word_wr", k_wr, 1'b1, 32'h0a4, 1'b1, 32'h1234abcd, 32'h1234abcd);
		add_row("word_rd_back", k_rd, 1'b1, 32'h0a4, 1'b1, 32'h0, 32'h1234abcd);
		add_row("wr_then_rd", k_wrrd, 1'b1, 32'h380, 1'b0, 32'hbeef0000, 32'hbeef0000);
		add_row("dc_line", k_rd, 1'b1, 32'h3c0, 1'b0, 32'h0, 32'h5a5a03c0);
		cycle_limit = rows.size() * 200;
		repeat (3) @(posedge clk);
		#2;
		rst = 1'b1;
		@(negedge clk);
		if (!(ic_rd_rdy && dc_rd_rdy && dc_wr_rdy) || arvalid || awvalid || wvalid
				|| ic_ret.valid || dc_ret.valid) begin
			fail_run("bridge is not idle after reset");
		end
		@(posedge clk);
		#2;
		foreach (rows[i]) begin
			run_row(i);
		end
		$display("TEST OK");
		$finish;
	end

endmodule

// ==== axi_cache_bridge.f ====
+incdir+hw
hw/axi_bridge_pkg.sv
hw/axi_rd_path.sv
hw/axi_wr_path.sv
hw/axi_cache_bridge.sv
sim/axi_slave_model.sv
sim/tb_axi_cache_bridge.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
	-f axi_cache_bridge.f --top-module tb_axi_cache_bridge -o tb_axi_cache_bridge \
	|| { echo "build failed"; exit 1; }
out=$(./obj_dir/tb_axi_cache_bridge)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "TEST OK" && exit 0 || exit 1
